//--- sim/core_bus_cases.txt
# kind  address  data  width  expected, all hex
# Notes: CR data is the rready delay in cycles, F and FD expect the whole line
CR 0 0 0 1
F 1000 0 0 c0de100cc0de1008c0de1004c0de1000
F 2010 0 0 c0de201cc0de2018c0de2014c0de2010
DW 20 11223344 2 0
DW 21 aa 0 0
DW 23 bb 0 0
DR 20 0 2 bb22aa44
DW 20 55 0 0
DW 22 66 0 0
DR 20 0 0 bb66aa55
DW 24 aabbccdd 2 0
DW 24 1234 1 0
DW 26 5678 1 0
DR 26 0 1 56781234
DR 28 0 2 5a5a0028
DW 2d ffffff99 0 0
DR 2c 0 2 5a5a992c
CR 4 0 0 2
CR 8 2 0 e
CR c 0 0 2010
CW 4 0 0 0
CR 4 0 0 0
CW 8 0 0 0
CR 8 0 0 0
CW 0 0 0 0
CR 0 5 0 0
FD 3000 0 0 c0de300cc0de3008c0de3004c0de3000
CR 4 0 0 1
CR c 4 0 3000
CW 2 ffffffff 0 0
CR 2 0 0 0
CR 0 0 0 1
CR 4 3 0 1
CR c 0 0 3000

//--- files.f
src/core_bus_pkg.sv
src/line_fetch.sv
src/dmem_bridge.sv
src/bus_csr.sv
src/core_bus_top.sv
sim/clk_gen.sv
sim/tb_core_bus.sv

//--- sim/tb_core_bus.sv
`timescale 1ns/1ps
`default_nettype none

module tb_core_bus;

    import core_bus_pkg::*;

    typedef struct packed {
        logic [15:0] kind;   // One or two ASCII letters
        addr_t       addr;
        word_t       data;
        logic [3:0]  width;
        line_t       expected;
    } case_t;

    logic        clk_core;
    logic        rst_core;
    logic        imem_req_i;
    addr_t       imem_addr_i;
    line_t       imem_line_o;
    logic        imem_resp_o;
    logic        dmem_req_i;
    logic        dmem_we_i;
    dmem_width_t dmem_width_i;
    addr_t       dmem_addr_i;
    word_t       dmem_wdata_i;
    word_t       dmem_rdata_o;
    logic        dmem_resp_o;
    wb_req_t     imem_wb_o;
    wb_rsp_t     imem_wb_i;
    wb_req_t     dmem_wb_o;
    wb_rsp_t     dmem_wb_i;
    axil_req_t   axil_i;
    axil_rsp_t   axil_o;

    case_t  cases[$];
    word_t  dmem[16];
    integer seed = 32'h1f6a;
    int     errors = 0;
    int     limit = 0;

    clk_gen u_clk_gen (.clk_core_o(clk_core), .rst_core_o(rst_core));

    core_bus_top u_core_bus_top (.*);

    // Instruction memory returns the word address xor a tag
    initial begin : imem_model
        int delay;
        imem_wb_i = '0;
        forever begin
            @(negedge clk_core);
            imem_wb_i = '0;
            if (imem_wb_o.cyc && imem_wb_o.stb) begin
                delay = $unsigned($random(seed)) % 8;
                repeat (delay) @(negedge clk_core);
                imem_wb_i.ack   = 1'b1;
                imem_wb_i.rdata = imem_wb_o.addr ^ 32'hc0de_0000;
            end
        end
    end

    initial begin : dmem_model
        int delay;
        int idx;
        dmem_wb_i = '0;
        for (int i = 0; i < 16; i++) begin
            dmem[i] = word_t'(i * 4) ^ 32'h5a5a_0000;   // Byte address xor tag
        end
        forever begin
            @(negedge clk_core);
            dmem_wb_i = '0;
            if (dmem_wb_o.cyc && dmem_wb_o.stb) begin
                delay = $unsigned($random(seed)) % 8;
                repeat (delay) @(negedge clk_core);
                idx = dmem_wb_o.addr[5:2];
                for (int b = 0; b < 4; b++) begin
                    if (dmem_wb_o.we && dmem_wb_o.wstrb[b]) begin
                        dmem[idx][8*b +: 8] = dmem_wb_o.wdata[8*b +: 8];
                    end
                end
                dmem_wb_i.ack   = 1'b1;
                dmem_wb_i.rdata = dmem[idx];
            end
        end
    end

    task automatic check_line(input line_t got, input line_t exp, input addr_t addr);
        if (got !== exp) begin
            errors++;
            $display("error at %0t: line at %h is %h, expected %h", $time, addr, got, exp);
        end
    endtask

    task automatic check_data(input word_t got, input word_t exp, input addr_t addr);
        if (got !== exp) begin
            errors++;
            $display("error at %0t: data at %h is %h, expected %h", $time, addr, got, exp);
        end
    endtask

    task automatic check_reg(input word_t got, input word_t exp, input csr_addr_t addr);
        if (got !== exp) begin
            errors++;
            $display("error at %0t: register %h is %h, expected %h", $time, addr, got, exp);
        end
    endtask

    task automatic check_resp(input logic [1:0] got, input string chan);
        if (got !== AXI_RESP_OKAY) begin
            errors++;
            $display("error at %0t: %s response %b, expected OKAY", $time, chan, got);
        end
    endtask

    task automatic run_fetch(input addr_t addr, output line_t line);
        @(negedge clk_core);
        imem_req_i  = 1'b1;
        imem_addr_i = addr;
        @(negedge clk_core);
        imem_req_i = 1'b0;
        while (!imem_resp_o) @(negedge clk_core);
        line = imem_line_o;
    endtask

    task automatic run_data(input logic we, input dmem_width_t width, input addr_t addr,
                            input word_t wdata, output word_t rdata);
        @(negedge clk_core);
        dmem_req_i   = 1'b1;
        dmem_we_i    = we;
        dmem_width_i = width;
        dmem_addr_i  = addr;
        dmem_wdata_i = wdata;
        @(negedge clk_core);
        dmem_req_i = 1'b0;
        while (!dmem_resp_o) @(negedge clk_core);
        rdata = dmem_rdata_o;
    endtask

    task automatic axil_write(input csr_addr_t addr, input word_t data);
        @(negedge clk_core);
        axil_i.awvalid = 1'b1;
        axil_i.awaddr  = addr;
        axil_i.wvalid  = 1'b1;
        axil_i.wdata   = data;
        axil_i.wstrb   = '1;
        axil_i.bready  = 1'b1;
        @(negedge clk_core);
        while (!axil_o.awready) @(negedge clk_core);
        if (axil_o.wready !== 1'b1) begin
            errors++;
            $display("error at %0t: wready is %b while awready is high", $time, axil_o.wready);
        end
        @(negedge clk_core);   // Handshake on the edge before
        axil_i.awvalid = 1'b0;
        axil_i.wvalid  = 1'b0;
        while (!axil_o.bvalid) @(negedge clk_core);
        check_resp(axil_o.bresp, "write");
        @(negedge clk_core);
        axil_i.bready = 1'b0;
    endtask

    task automatic axil_read(input csr_addr_t addr, input int delay, output word_t data);
        @(negedge clk_core);
        axil_i.arvalid = 1'b1;
        axil_i.araddr  = addr;
        @(negedge clk_core);
        while (!axil_o.arready) @(negedge clk_core);
        @(negedge clk_core);
        axil_i.arvalid = 1'b0;
        while (!axil_o.rvalid) @(negedge clk_core);
        repeat (delay) @(negedge clk_core);   // Slow master
        if (!axil_o.rvalid) begin
            errors++;
            $display("error at %0t: rvalid dropped before rready", $time);
        end
        data = axil_o.rdata;
        check_resp(axil_o.rresp, "read");
        axil_i.rready = 1'b1;
        @(negedge clk_core);
        axil_i.rready = 1'b0;
    endtask

    // Request held with fetch off, then CTRL set to let it through
    task automatic fetch_gated(input addr_t addr, output line_t line);
        @(negedge clk_core);
        imem_req_i  = 1'b1;
        imem_addr_i = addr;
        repeat (50) begin
            @(negedge clk_core);
            if (imem_wb_o.cyc || imem_resp_o) begin
                errors++;
                $display("error at %0t: fetch activity while fetch is disabled", $time);
            end
        end
        axil_write(CSR_CTRL, 32'd1);
        imem_req_i = 1'b0;
        while (!imem_resp_o) @(negedge clk_core);
        line = imem_line_o;
    endtask

    task automatic run_case(input case_t c);
        line_t got_line;
        word_t got_word;
        case (c.kind)
            "F": begin
                run_fetch(c.addr, got_line);
                check_line(got_line, c.expected, c.addr);
            end
            "FD": begin
                fetch_gated(c.addr, got_line);
                check_line(got_line, c.expected, c.addr);
            end
            "DW": run_data(1'b1, dmem_width_t'(c.width), c.addr, c.data, got_word);
            "DR": begin
                run_data(1'b0, dmem_width_t'(c.width), c.addr, c.data, got_word);
                check_data(got_word, c.expected[31:0], c.addr);
            end
            "CW": axil_write(csr_addr_t'(c.addr), c.data);
            "CR": begin
                axil_read(csr_addr_t'(c.addr), int'(c.data), got_word);
                check_reg(got_word, c.expected[31:0], csr_addr_t'(c.addr));
            end
            default: begin
                errors++;
                $display("Unknown case kind %s in the case file", c.kind);
            end
        endcase
    endtask

    initial begin : watchdog
        int cycles;
        cycles = 0;
        wait (limit > 0);
        while (cycles < limit) begin
            @(posedge clk_core);
            cycles++;
        end
        $display("Timeout: the run hung and was stopped after %0d cycles", cycles);
        $display("CHECKS FAILED");
        $finish;
    end

    initial begin : main
        int               fd;
        int               n;
        logic [15:0]      kind;
        addr_t            addr;
        word_t            data;
        logic [3:0]       width;
        line_t            expected;
        logic [8*200-1:0] text;
        imem_req_i   = 1'b0;
        imem_addr_i  = '0;
        dmem_req_i   = 1'b0;
        dmem_we_i    = 1'b0;
        dmem_width_i = WIDTH_WORD;
        dmem_addr_i  = '0;
        dmem_wdata_i = '0;
        axil_i       = '0;
        fd = $fopen("sim/core_bus_cases.txt", "r");
        if (fd == 0) begin
            $display("Could not open sim/core_bus_cases.txt, no case was run");
            $display("CHECKS FAILED");
            $finish;
        end else begin
            while (!$feof(fd)) begin
                text = '0;
                if ($fgets(text, fd) != 0) begin
                    n = $sscanf(text, "%s %h %h %h %h", kind, addr, data, width, expected);
                    if (n == 5) begin   // Comments and blank lines fall out here
                        cases.push_back('{kind, addr, data, width, expected});
                    end
                end
            end
            $fclose(fd);
            if (cases.size() == 0) begin
                errors++;
                $display("The case file holds no cases");
            end
            limit = cases.size() * 60 + 100;
            wait (rst_core === 1'b1);
            wait (rst_core === 1'b0);
            foreach (cases[i]) begin
                run_case(cases[i]);
            end
            $display("Cases run: %0d, errors: %0d", cases.size(), errors);
            if (errors == 0) begin
                $display("ALL CHECKS PASSED");
            end else begin
                $display("CHECKS FAILED");
            end
            $finish;
        end
    end

endmodule

`default_nettype wire

//--- sim/clk_gen.sv
`timescale 1ns/1ps
`default_nettype none

module clk_gen (
    output logic clk_core_o,
    output logic rst_core_o
);

    initial begin
        clk_core_o = 1'b0;
        forever #20 clk_core_o = ~clk_core_o;   // 40 ns period
    end

    // Reset for 10 cycles, released on a falling edge
    initial begin
        rst_core_o = 1'b1;
        repeat (10) @(posedge clk_core_o);
        @(negedge clk_core_o);
        rst_core_o = 1'b0;
    end

endmodule

`default_nettype wire

//--- src/core_bus_top.sv
`timescale 1ns/1ps
`default_nettype none

module core_bus_top (
    input  wire logic                      clk_core,
    input  wire logic                      rst_core,

    // Core instruction port
    input  wire logic                      imem_req_i,
    input  wire core_bus_pkg::addr_t       imem_addr_i,
    output core_bus_pkg::line_t            imem_line_o,
    output logic                           imem_resp_o,

    // Core data port
    input  wire logic                      dmem_req_i,
    input  wire logic                      dmem_we_i,
    input  wire core_bus_pkg::dmem_width_t dmem_width_i,
    input  wire core_bus_pkg::addr_t       dmem_addr_i,
    input  wire core_bus_pkg::word_t       dmem_wdata_i,
    output core_bus_pkg::word_t            dmem_rdata_o,
    output logic                           dmem_resp_o,

    output core_bus_pkg::wb_req_t          imem_wb_o,
    input  wire core_bus_pkg::wb_rsp_t     imem_wb_i,
    output core_bus_pkg::wb_req_t          dmem_wb_o,
    input  wire core_bus_pkg::wb_rsp_t     dmem_wb_i,

    input  wire core_bus_pkg::axil_req_t   axil_i,
    output core_bus_pkg::axil_rsp_t        axil_o
);

    import core_bus_pkg::*;

    logic  fetch_en;
    addr_t line_addr;

    line_fetch u_line_fetch (
        .clk_core    (clk_core),
        .rst_core    (rst_core),
        .fetch_en_i  (fetch_en),
        .imem_req_i  (imem_req_i),
        .imem_addr_i (imem_addr_i),
        .imem_line_o (imem_line_o),
        .imem_resp_o (imem_resp_o),
        .line_addr_o (line_addr),
        .wb_o        (imem_wb_o),
        .wb_i        (imem_wb_i)
    );

    dmem_bridge u_dmem_bridge (
        .clk_core     (clk_core),
        .rst_core     (rst_core),
        .dmem_req_i   (dmem_req_i),
        .dmem_we_i    (dmem_we_i),
        .dmem_width_i (dmem_width_i),
        .dmem_addr_i  (dmem_addr_i),
        .dmem_wdata_i (dmem_wdata_i),
        .dmem_rdata_o (dmem_rdata_o),
        .dmem_resp_o  (dmem_resp_o),
        .wb_o         (dmem_wb_o),
        .wb_i         (dmem_wb_i)
    );

    // Counts completions from both engines
    bus_csr u_bus_csr (
        .clk_core     (clk_core),
        .rst_core     (rst_core),
        .axil_i       (axil_i),
        .axil_o       (axil_o),
        .fetch_done_i (imem_resp_o),
        .line_addr_i  (line_addr),
        .dmem_done_i  (dmem_resp_o),
        .fetch_en_o   (fetch_en)
    );

endmodule

`default_nettype wire

//--- src/bus_csr.sv
`timescale 1ns/1ps
`default_nettype none

module bus_csr (
    input  wire logic                    clk_core,
    input  wire logic                    rst_core,
    input  wire core_bus_pkg::axil_req_t axil_i,
    output core_bus_pkg::axil_rsp_t      axil_o,
    input  wire logic                    fetch_done_i,
    input  wire core_bus_pkg::addr_t     line_addr_i,
    input  wire logic                    dmem_done_i,
    output logic                         fetch_en_o
);

    import core_bus_pkg::*;

    logic  wr_ready_q;
    logic  bvalid_q;
    logic  rd_ready_q;
    logic  rvalid_q;
    word_t rdata_q;
    logic  fetch_en_q;
    word_t fetch_cnt;
    word_t dmem_cnt;
    addr_t last_line;
    logic  wr_hs;
    logic  rd_hs;
    word_t rd_mux;

    // Valids are held by the master, so a registered ready completes them
    assign wr_hs = wr_ready_q && axil_i.awvalid && axil_i.wvalid;
    assign rd_hs = rd_ready_q && axil_i.arvalid;

    always_ff @(posedge clk_core) begin
        if (rst_core) begin
            wr_ready_q <= 1'b0;
            bvalid_q   <= 1'b0;
            rd_ready_q <= 1'b0;
            rvalid_q   <= 1'b0;
        end else begin
            wr_ready_q <= axil_i.awvalid && axil_i.wvalid && !wr_ready_q && !bvalid_q;
            if (wr_hs) begin
                bvalid_q <= 1'b1;
            end else if (axil_i.bready) begin
                bvalid_q <= 1'b0;
            end
            rd_ready_q <= axil_i.arvalid && !rd_ready_q && !rvalid_q;
            if (rd_hs) begin
                rvalid_q <= 1'b1;
            end else if (axil_i.rready) begin
                rvalid_q <= 1'b0;
            end
        end
    end

    // Register file, clear wins over count
    always_ff @(posedge clk_core) begin
        if (rst_core) begin
            fetch_en_q <= 1'b1;
            fetch_cnt  <= '0;
            dmem_cnt   <= '0;
            last_line  <= '0;
        end else begin
            if (wr_hs && axil_i.awaddr == CSR_CTRL && axil_i.wstrb[0]) begin
                fetch_en_q <= axil_i.wdata[0];
            end
            if (wr_hs && axil_i.awaddr == CSR_FETCH_CNT) begin
                fetch_cnt <= '0;
            end else if (fetch_done_i) begin
                fetch_cnt <= fetch_cnt + 1'b1;
            end
            if (wr_hs && axil_i.awaddr == CSR_DMEM_CNT) begin
                dmem_cnt <= '0;
            end else if (dmem_done_i) begin
                dmem_cnt <= dmem_cnt + 1'b1;
            end
            if (fetch_done_i) begin
                last_line <= line_addr_i;
            end
        end
    end

    always_comb begin
        case (axil_i.araddr)
            CSR_CTRL:      rd_mux = {31'd0, fetch_en_q};
            CSR_FETCH_CNT: rd_mux = fetch_cnt;
            CSR_DMEM_CNT:  rd_mux = dmem_cnt;
            CSR_LAST_LINE: rd_mux = last_line;
            default:       rd_mux = '0;   // Unmapped
        endcase
    end

    always_ff @(posedge clk_core) begin
        if (rd_hs) begin
            rdata_q <= rd_mux;
        end
    end

    always_comb begin
        axil_o.awready = wr_ready_q;
        axil_o.wready  = wr_ready_q;
        axil_o.bvalid  = bvalid_q;
        axil_o.bresp   = AXI_RESP_OKAY;
        axil_o.arready = rd_ready_q;
        axil_o.rvalid  = rvalid_q;
        axil_o.rdata   = rdata_q;
        axil_o.rresp   = AXI_RESP_OKAY;
    end

    assign fetch_en_o = fetch_en_q;

    a_b_hold: assert property (@(posedge clk_core) disable iff (rst_core)
        (axil_o.bvalid && !axil_i.bready) |=> axil_o.bvalid);

    a_r_hold: assert property (@(posedge clk_core) disable iff (rst_core)
        (axil_o.rvalid && !axil_i.rready) |=> (axil_o.rvalid && $stable(axil_o.rdata)));

endmodule

`default_nettype wire

//--- src/dmem_bridge.sv
`timescale 1ns/1ps
`default_nettype none

module dmem_bridge (
    input  wire logic                      clk_core,
    input  wire logic                      rst_core,
    input  wire logic                      dmem_req_i,
    input  wire logic                      dmem_we_i,
    input  wire core_bus_pkg::dmem_width_t dmem_width_i,
    input  wire core_bus_pkg::addr_t       dmem_addr_i,
    input  wire core_bus_pkg::word_t       dmem_wdata_i,
    output core_bus_pkg::word_t            dmem_rdata_o,
    output logic                           dmem_resp_o,
    output core_bus_pkg::wb_req_t          wb_o,
    input  wire core_bus_pkg::wb_rsp_t     wb_i
);

    import core_bus_pkg::*;

    logic   busy_q;
    logic   resp_q;
    logic   we_q;
    addr_t  addr_q;
    wstrb_t strb_q;
    word_t  wdata_q;
    word_t  rdata_q;
    wstrb_t strb_d;
    word_t  wdata_d;
    logic   accept;

    assign accept = dmem_req_i && !busy_q;

    // Lane select and data replication
    always_comb begin
        case (dmem_width_i)
            WIDTH_BYTE: begin
                strb_d  = wstrb_t'(4'b0001 << dmem_addr_i[1:0]);
                wdata_d = {4{dmem_wdata_i[7:0]}};
            end
            WIDTH_HALF: begin
                strb_d  = dmem_addr_i[1] ? 4'b1100 : 4'b0011;
                wdata_d = {2{dmem_wdata_i[15:0]}};
            end
            default: begin
                strb_d  = 4'b1111;
                wdata_d = dmem_wdata_i;
            end
        endcase
    end

    always_ff @(posedge clk_core) begin
        if (rst_core) begin
            busy_q <= 1'b0;
            resp_q <= 1'b0;
        end else begin
            resp_q <= busy_q && wb_i.ack;
            if (accept) begin
                busy_q <= 1'b1;
            end else if (wb_i.ack) begin
                busy_q <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk_core) begin
        if (accept) begin
            we_q    <= dmem_we_i;
            addr_q  <= {dmem_addr_i[31:2], 2'b00};   // Word aligned
            strb_q  <= strb_d;
            wdata_q <= wdata_d;
        end
        if (busy_q && wb_i.ack) begin
            rdata_q <= wb_i.rdata;
        end
    end

    always_comb begin
        wb_o.cyc   = busy_q;
        wb_o.stb   = busy_q;
        wb_o.we    = we_q;
        wb_o.wstrb = strb_q;
        wb_o.addr  = addr_q;
        wb_o.wdata = wdata_q;
    end

    assign dmem_rdata_o = rdata_q;
    assign dmem_resp_o  = resp_q;

    a_width_legal: assert property (@(posedge clk_core) disable iff (rst_core)
        accept |-> (dmem_width_i != 2'd3));

endmodule

`default_nettype wire

//--- src/line_fetch.sv
`timescale 1ns/1ps
`default_nettype none

module line_fetch (
    input  wire logic                 clk_core,
    input  wire logic                 rst_core,
    input  wire logic                 fetch_en_i,
    input  wire logic                 imem_req_i,
    input  wire core_bus_pkg::addr_t  imem_addr_i,
    output core_bus_pkg::line_t       imem_line_o,
    output logic                      imem_resp_o,
    output core_bus_pkg::addr_t       line_addr_o,
    output core_bus_pkg::wb_req_t     wb_o,
    input  wire core_bus_pkg::wb_rsp_t wb_i
);

    import core_bus_pkg::*;

    fetch_state_t          state;
    logic [LINE_IDX_W-1:0] word_idx;
    addr_t                 base_addr;
    line_t                 line_buf;
    line_t                 line_q;
    logic                  resp_q;
    logic                  accept;
    logic                  word_ack;
    logic                  last_word;

    assign accept    = (state == FETCH_IDLE) && imem_req_i && fetch_en_i;
    assign word_ack  = (state == FETCH_REQ) && wb_i.ack;
    assign last_word = (word_idx == LINE_IDX_W'(LINE_WORDS - 1));

    always_ff @(posedge clk_core) begin
        if (rst_core) begin
            state    <= FETCH_IDLE;
            word_idx <= '0;
            resp_q   <= 1'b0;
        end else begin
            resp_q <= (state == FETCH_ASM);   // Pulse follows assembly
            case (state)
                FETCH_IDLE: begin
                    if (accept) begin
                        word_idx <= '0;
                        state    <= FETCH_REQ;
                    end
                end
                FETCH_REQ: begin
                    if (wb_i.ack) begin
                        word_idx <= word_idx + 1'b1;
                        state    <= last_word ? FETCH_ASM : FETCH_GAP;
                    end
                end
                FETCH_GAP: state <= FETCH_REQ;
                FETCH_ASM: state <= FETCH_IDLE;
                default:   state <= FETCH_IDLE;
            endcase
        end
    end

    // Address and line data
    always_ff @(posedge clk_core) begin
        if (accept) begin
            base_addr <= imem_addr_i;
        end
        if (word_ack) begin
            line_buf[word_idx*32 +: 32] <= wb_i.rdata;
        end
        if (state == FETCH_ASM) begin
            line_q <= line_buf;   // Output stays stable through the next fill
        end
    end

    always_comb begin
        wb_o       = '0;
        wb_o.cyc   = (state == FETCH_REQ);
        wb_o.stb   = (state == FETCH_REQ);
        wb_o.we    = 1'b0;
        wb_o.wstrb = '1;
        wb_o.addr  = base_addr + addr_t'({word_idx, 2'b00});
    end

    assign imem_line_o = line_q;
    assign imem_resp_o = resp_q;
    assign line_addr_o = base_addr;

    // Request must not move while the slave is still working on it
    a_wb_hold: assert property (@(posedge clk_core) disable iff (rst_core)
        (wb_o.cyc && !wb_i.ack) |=> (wb_o.cyc && $stable(wb_o)));

    a_resp_pulse: assert property (@(posedge clk_core) disable iff (rst_core)
        imem_resp_o |=> !imem_resp_o);

endmodule

`default_nettype wire

//--- src/core_bus_pkg.sv
`default_nettype none

package core_bus_pkg;

    typedef logic [31:0]  word_t;
    typedef logic [31:0]  addr_t;
    typedef logic [127:0] line_t;   // Word 0 in the low bits
    typedef logic [3:0]   wstrb_t;
    typedef logic [1:0]   dmem_width_t;
    typedef logic [3:0]   csr_addr_t;

    localparam int LINE_WORDS = 4;
    localparam int LINE_IDX_W = $clog2(LINE_WORDS);

    // Access width codes
    localparam dmem_width_t WIDTH_BYTE = 2'd0;
    localparam dmem_width_t WIDTH_HALF = 2'd1;
    localparam dmem_width_t WIDTH_WORD = 2'd2;

    // Register map
    localparam csr_addr_t CSR_CTRL      = 4'h0;
    localparam csr_addr_t CSR_FETCH_CNT = 4'h4;
    localparam csr_addr_t CSR_DMEM_CNT  = 4'h8;
    localparam csr_addr_t CSR_LAST_LINE = 4'hC;

    localparam logic [1:0] AXI_RESP_OKAY = 2'b00;

    typedef struct packed {
        logic   cyc;
        logic   stb;
        logic   we;
        wstrb_t wstrb;
        addr_t  addr;
        word_t  wdata;
    } wb_req_t;

    typedef struct packed {
        logic  ack;
        word_t rdata;
    } wb_rsp_t;

    typedef struct packed {
        logic      awvalid;
        csr_addr_t awaddr;
        logic      wvalid;
        word_t     wdata;
        wstrb_t    wstrb;
        logic      bready;
        logic      arvalid;
        csr_addr_t araddr;
        logic      rready;
    } axil_req_t;

    typedef struct packed {
        logic       awready;
        logic       wready;
        logic       bvalid;
        logic [1:0] bresp;
        logic       arready;
        logic       rvalid;
        word_t      rdata;
        logic [1:0] rresp;
    } axil_rsp_t;

    typedef enum logic [1:0] {
        FETCH_IDLE = 2'd0,
        FETCH_REQ  = 2'd1,  // Wishbone cycle open
        FETCH_GAP  = 2'd2,  // cyc low between words
        FETCH_ASM  = 2'd3
    } fetch_state_t;

endpackage

`default_nettype wire
